/* Bender.yml */
package:
  name: soc_interconnect

sources:
  # Shared package and interface
  - files:
      - common/soc_interconnect_pkg.sv
      - common/tcdm_bank_if.sv
  # RTL
  - files:
      - hdl/tcdm_addr_decoder.sv
      - interleaved_xbar/bank_arbiter.sv
      - interleaved_xbar/response_router.sv
      - hdl/soc_interconnect.sv
  # Verification
  - target: test
    files:
      - verification/soc_interconnect_chk.sv
      - verification/tb_soc_interconnect.sv

/* common/soc_interconnect_pkg.sv */
// Shared bus widths, request payload and error pattern for the interleaved interconnect

package soc_interconnect_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    // The TCDM bus is a plain 32 bit word bus
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;

    // One byte enable per byte lane
    localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BE_WIDTH-1:0]   be_t;

    //////////////////////////////////////////////////
    // Request payload
    //////////////////////////////////////////////////

    // Everything a master presents next to its req strobe
    // The write enable follows the TCDM convention, high means read
    typedef struct packed {
        addr_t addr;
        logic  wen;
        be_t   be;
        data_t wdata;
    } tcdm_req_t;

    //////////////////////////////////////////////////
    // Error slave
    //////////////////////////////////////////////////

    // Read data returned for any access outside the interleaved region
    localparam data_t ERROR_RESPONSE = 32'hBADACCE5;

endpackage : soc_interconnect_pkg

/* common/tcdm_bank_if.sv */
// Per-bank request, grant and winner bundle shared by decoder, arbiter and router

`timescale 1ns/1ps

interface tcdm_bank_if #(
    parameter int unsigned NR_MASTERS = 4
);

    // Index width of one master, kept at one bit for a single master
    localparam int unsigned IDX_W = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

    // One request bit per master that targets this bank
    logic [NR_MASTERS-1:0] req;

    // One-hot grant back toward the masters, zero while the bank stalls
    logic [NR_MASTERS-1:0] gnt;

    // Master picked by the round-robin arbiter in this cycle
    logic [IDX_W-1:0]      winner;

    // High whenever some master requests this bank
    logic                  winner_valid;

    // The decoder only raises requests
    modport decoder (
        output req
    );

    // The arbiter turns requests into a single grant
    modport arbiter (
        input  req,
        output gnt,
        output winner,
        output winner_valid
    );

    // The router needs to know who got the bank to steer read data back
    modport router (
        input gnt,
        input winner,
        input winner_valid
    );

endinterface : tcdm_bank_if

/* filelist.f */
common/soc_interconnect_pkg.sv
common/tcdm_bank_if.sv
hdl/tcdm_addr_decoder.sv
interleaved_xbar/bank_arbiter.sv
interleaved_xbar/response_router.sv
hdl/soc_interconnect.sv
verification/soc_interconnect_chk.sv
verification/tb_soc_interconnect.sv

/* hdl/soc_interconnect.sv */
// Interleaved TCDM interconnect from a set of masters to word-interleaved SRAM banks

`timescale 1ns/1ps

module soc_interconnect
    import soc_interconnect_pkg::*;
#(
    parameter int unsigned NR_MASTERS = 4,
    parameter int unsigned NR_BANKS   = 4
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // Interleaved region, both limits inclusive
    input  addr_t                 intlv_start_i,
    input  addr_t                 intlv_end_i,
    // Master request side
    input  logic [NR_MASTERS-1:0] master_req_i,
    input  addr_t                 master_add_i [NR_MASTERS],
    input  logic [NR_MASTERS-1:0] master_wen_i,
    input  be_t                   master_be_i [NR_MASTERS],
    input  data_t                 master_wdata_i [NR_MASTERS],
    // Master response side
    output logic [NR_MASTERS-1:0] master_gnt_o,
    output logic [NR_MASTERS-1:0] master_r_valid_o,
    output data_t                 master_r_rdata_o [NR_MASTERS],
    output logic [NR_MASTERS-1:0] master_r_opc_o,
    // Bank ports
    output logic [NR_BANKS-1:0]   bank_req_o,
    output addr_t                 bank_add_o [NR_BANKS],
    output logic [NR_BANKS-1:0]   bank_wen_o,
    output be_t                   bank_be_o [NR_BANKS],
    output data_t                 bank_wdata_o [NR_BANKS],
    input  logic [NR_BANKS-1:0]   bank_gnt_i,
    input  data_t                 bank_rdata_i [NR_BANKS]
);

    tcdm_req_t             master_payload [NR_MASTERS];
    logic [NR_MASTERS-1:0] err_req;

    // One request/grant bundle per bank
    tcdm_bank_if #(.NR_MASTERS(NR_MASTERS)) bank_bus [NR_BANKS] ();

    // Bundle each master's payload so the arbiters can mux it as one word
    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_payload
        assign master_payload[m] = '{
            addr:  master_add_i[m],
            wen:   master_wen_i[m],
            be:    master_be_i[m],
            wdata: master_wdata_i[m]
        };
    end

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    tcdm_addr_decoder #(
        .NR_MASTERS (NR_MASTERS),
        .NR_BANKS   (NR_BANKS)
    ) i_addr_decoder (
        .intlv_start_i (intlv_start_i),
        .intlv_end_i   (intlv_end_i),
        .master_req_i  (master_req_i),
        .master_add_i  (master_add_i),
        .err_req_o     (err_req),
        .bank_o        (bank_bus)
    );

    //////////////////////////////////////////////////
    // Crossbar, one arbiter per bank
    //////////////////////////////////////////////////

    for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank_arb
        bank_arbiter #(
            .NR_MASTERS (NR_MASTERS),
            .NR_BANKS   (NR_BANKS)
        ) i_bank_arbiter (
            .clk_i        (clk_i),
            .reset_i      (reset_i),
            .req_i        (master_payload),
            .bank_gnt_i   (bank_gnt_i[b]),
            .bank_req_o   (bank_req_o[b]),
            .bank_add_o   (bank_add_o[b]),
            .bank_wen_o   (bank_wen_o[b]),
            .bank_be_o    (bank_be_o[b]),
            .bank_wdata_o (bank_wdata_o[b]),
            .bus          (bank_bus[b])
        );
    end

    // Grants out now, responses one cycle later from a bank or the error slave
    response_router #(
        .NR_MASTERS (NR_MASTERS),
        .NR_BANKS   (NR_BANKS)
    ) i_response_router (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .err_req_i        (err_req),
        .bank_rdata_i     (bank_rdata_i),
        .master_gnt_o     (master_gnt_o),
        .master_r_valid_o (master_r_valid_o),
        .master_r_rdata_o (master_r_rdata_o),
        .master_r_opc_o   (master_r_opc_o),
        .bus              (bank_bus)
    );

endmodule : soc_interconnect

/* hdl/tcdm_addr_decoder.sv */
// Interleaved region check and word-address bank selection for every master

`timescale 1ns/1ps

module tcdm_addr_decoder
    import soc_interconnect_pkg::*;
#(
    parameter int unsigned NR_MASTERS = 4,
    parameter int unsigned NR_BANKS   = 4
) (
    input  addr_t                 intlv_start_i,
    input  addr_t                 intlv_end_i,
    input  logic [NR_MASTERS-1:0] master_req_i,
    input  addr_t                 master_add_i [NR_MASTERS],
    output logic [NR_MASTERS-1:0] err_req_o,
    tcdm_bank_if.decoder          bank_o [NR_BANKS]
);

    // Width of the bank select field, at least one bit so the slice stays legal
    localparam int unsigned BANK_SEL_W = (NR_BANKS > 1) ? $clog2(NR_BANKS) : 1;

    // Mask that collapses the select field to zero when there is only one bank
    localparam logic [BANK_SEL_W-1:0] BANK_MASK = BANK_SEL_W'(NR_BANKS - 1);

    logic [NR_MASTERS-1:0] req_matrix [NR_BANKS];

    always_comb begin
        logic [BANK_SEL_W-1:0] bank_sel;
        logic                  in_range;
        bank_sel   = '0;
        in_range   = 1'b0;
        req_matrix = '{default: '0};
        err_req_o  = '0;
        for (int unsigned m = 0; m < NR_MASTERS; m++) begin
            // Both region limits are inclusive
            in_range = (master_add_i[m] >= intlv_start_i) && (master_add_i[m] <= intlv_end_i);
            // Bank index sits right above the two byte-offset bits
            bank_sel = master_add_i[m][2 +: BANK_SEL_W] & BANK_MASK;
            if (master_req_i[m]) begin
                if (in_range) begin
                    req_matrix[bank_sel][m] = 1'b1;
                end else begin
                    // Anything outside the region is answered by the error slave
                    err_req_o[m] = 1'b1;
                end
            end
        end
    end

    // Interface arrays need constant indices, so each bank is driven on its own
    for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank_req
        assign bank_o[b].req = req_matrix[b];
    end

endmodule : tcdm_addr_decoder

/* interleaved_xbar/bank_arbiter.sv */
// Round-robin arbiter that forwards one master's request to a single SRAM bank

`timescale 1ns/1ps

module bank_arbiter
    import soc_interconnect_pkg::*;
#(
    parameter int unsigned NR_MASTERS = 4,
    parameter int unsigned NR_BANKS   = 4
) (
    input  logic         clk_i,
    input  logic         reset_i,
    input  tcdm_req_t    req_i [NR_MASTERS],
    input  logic         bank_gnt_i,
    output logic         bank_req_o,
    output addr_t        bank_add_o,
    output logic         bank_wen_o,
    output be_t          bank_be_o,
    output data_t        bank_wdata_o,
    tcdm_bank_if.arbiter bus
);

    localparam int unsigned IDX_W = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

    // Number of address bits consumed by byte offset and bank select
    localparam int unsigned DROP_W = 2 + $clog2(NR_BANKS);

    // Last master that was granted, the search starts right after it
    logic [IDX_W-1:0]      rr_q;
    logic [IDX_W-1:0]      winner;
    logic                  found;
    logic [NR_MASTERS-1:0] winner_onehot;

    //////////////////////////////////////////////////
    // Round-robin pick
    //////////////////////////////////////////////////

    always_comb begin
        int unsigned idx;
        idx    = 0;
        winner = '0;
        found  = 1'b0;
        // Walk all masters once, starting one past the previous winner
        for (int unsigned i = 1; i <= NR_MASTERS; i++) begin
            idx = (int'(rr_q) + i) % NR_MASTERS;
            if (!found && bus.req[idx]) begin
                winner = IDX_W'(idx);
                found  = 1'b1;
            end
        end
    end

    always_comb begin
        winner_onehot         = '0;
        winner_onehot[winner] = 1'b1;
    end

    // A stalled bank withholds the grant, so the master keeps its request up
    // Nothing is granted while the interconnect is held in reset
    assign bus.gnt          = (found && bank_gnt_i && !reset_i) ? winner_onehot : '0;
    assign bus.winner       = winner;
    assign bus.winner_valid = found;

    //////////////////////////////////////////////////
    // Bank port
    //////////////////////////////////////////////////

    // The bank only sees the word address inside itself
    assign bank_req_o   = found && !reset_i;
    assign bank_add_o   = req_i[winner].addr >> DROP_W;
    assign bank_wen_o   = req_i[winner].wen;
    assign bank_be_o    = req_i[winner].be;
    assign bank_wdata_o = req_i[winner].wdata;

    // Start after master NR_MASTERS-1 so master 0 has priority out of reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_q <= IDX_W'(NR_MASTERS - 1);
        end else if (found && bank_gnt_i) begin
            // Pointer only moves when the bank really took the access
            rr_q <= winner;
        end
    end

endmodule : bank_arbiter

/* interleaved_xbar/response_router.sv */
// Merges bank and error grants and steers one-cycle read responses back to the masters

`timescale 1ns/1ps

module response_router
    import soc_interconnect_pkg::*;
#(
    parameter int unsigned NR_MASTERS = 4,
    parameter int unsigned NR_BANKS   = 4
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [NR_MASTERS-1:0] err_req_i,
    input  data_t                 bank_rdata_i [NR_BANKS],
    output logic [NR_MASTERS-1:0] master_gnt_o,
    output logic [NR_MASTERS-1:0] master_r_valid_o,
    output data_t                 master_r_rdata_o [NR_MASTERS],
    output logic [NR_MASTERS-1:0] master_r_opc_o,
    tcdm_bank_if.router           bus [NR_BANKS]
);

    localparam int unsigned IDX_W  = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;
    localparam int unsigned BANK_W = (NR_BANKS > 1) ? $clog2(NR_BANKS) : 1;

    logic [NR_MASTERS-1:0] bank_gnt    [NR_BANKS];
    logic [IDX_W-1:0]      bank_winner [NR_BANKS];
    logic [NR_BANKS-1:0]   bank_fire;
    logic [BANK_W-1:0]     bank_idx_d  [NR_MASTERS];
    logic [BANK_W-1:0]     bank_idx_q  [NR_MASTERS];
    logic [NR_MASTERS-1:0] r_valid_q;
    logic [NR_MASTERS-1:0] r_opc_q;

    // Pull the per-bank signals out of the interface array
    for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank_taps
        assign bank_gnt[b]    = bus[b].gnt;
        assign bank_winner[b] = bus[b].winner;
        assign bank_fire[b]   = bus[b].winner_valid & (|bus[b].gnt);
    end

    //////////////////////////////////////////////////
    // Grant merge
    //////////////////////////////////////////////////

    always_comb begin
        // The error slave never stalls, so an error request is granted at once
        // No error grant while the interconnect is held in reset
        master_gnt_o = reset_i ? '0 : err_req_i;
        bank_idx_d   = '{default: '0};
        for (int unsigned b = 0; b < NR_BANKS; b++) begin
            master_gnt_o = master_gnt_o | bank_gnt[b];
            // Record which bank the winning master will hear back from
            if (bank_fire[b]) begin
                bank_idx_d[bank_winner[b]] = BANK_W'(b);
            end
        end
    end

    //////////////////////////////////////////////////
    // Response stage
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            r_valid_q <= '0;
            r_opc_q   <= '0;
        end else begin
            r_valid_q <= master_gnt_o;
            r_opc_q   <= err_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        bank_idx_q <= bank_idx_d;
    end

    assign master_r_valid_o = r_valid_q;
    assign master_r_opc_o   = r_opc_q;

    // Banks answer one cycle after their grant, which lines up with this stage
    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_rdata
        assign master_r_rdata_o[m] = r_opc_q[m] ? ERROR_RESPONSE : bank_rdata_i[bank_idx_q[m]];
    end

endmodule : response_router

/* verification/soc_interconnect_chk.sv */
// Protocol checker for the interleaved interconnect, bound to the top level

`timescale 1ns/1ps

module soc_interconnect_chk
    import soc_interconnect_pkg::*;
#(
    parameter int unsigned NR_MASTERS = 4,
    parameter int unsigned NR_BANKS   = 4
) (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic [NR_MASTERS-1:0] master_req_i,
    input addr_t                 master_add_i [NR_MASTERS],
    input logic [NR_MASTERS-1:0] err_req_i,
    input logic [NR_MASTERS-1:0] master_gnt_i,
    input logic [NR_MASTERS-1:0] master_r_valid_i,
    input logic [NR_BANKS-1:0]   bank_req_i
);

    // Grants sorted by the bank the granted address maps to
    logic [NR_MASTERS-1:0] bank_gnt [NR_BANKS];

    // Number of failed assertions so far
    int fail_count = 0;

    always_comb begin
        bank_gnt = '{default: '0};
        for (int unsigned m = 0; m < NR_MASTERS; m++) begin
            if (master_gnt_i[m] && !err_req_i[m]) begin
                bank_gnt[(master_add_i[m] >> 2) % NR_BANKS][m] = 1'b1;
            end
        end
    end

    // Nothing may be granted or sent to a bank while the interconnect is held in reset
    assert property (@(posedge clk_i) reset_i |-> master_gnt_i == '0 && bank_req_i == '0)
        else begin
            fail_count++;
            $error("grant or bank request during reset");
        end

    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_master
        // Response exactly one cycle after the grant, never without one
        assert property (@(posedge clk_i) disable iff (reset_i)
                         master_gnt_i[m] |=> master_r_valid_i[m])
            else begin
                fail_count++;
                $error("master %0d has no response one cycle after its grant", m);
            end
        assert property (@(posedge clk_i) disable iff (reset_i)
                         master_r_valid_i[m] |-> $past(master_gnt_i[m]))
            else begin
                fail_count++;
                $error("master %0d has a response without a grant", m);
            end
    end

    for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank
        assert property (@(posedge clk_i) disable iff (reset_i)
                         bank_req_i[b] |-> |(master_req_i & ~err_req_i))
            else begin
                fail_count++;
                $error("bank %0d requested with no in-range master request", b);
            end
        assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(bank_gnt[b]))
            else begin
                fail_count++;
                $error("bank %0d granted to more than one master", b);
            end
    end

endmodule : soc_interconnect_chk

bind soc_interconnect soc_interconnect_chk #(
    .NR_MASTERS (NR_MASTERS),
    .NR_BANKS   (NR_BANKS)
) i_chk (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .master_req_i     (master_req_i),
    .master_add_i     (master_add_i),
    .err_req_i        (err_req),
    .master_gnt_i     (master_gnt_o),
    .master_r_valid_i (master_r_valid_o),
    .bank_req_i       (bank_req_o)
);

/* verification/tb_soc_interconnect.sv */
// Testbench for the interleaved interconnect with SRAM bank models and a reference memory

`timescale 1ns/1ps

module tb_soc_interconnect
    import soc_interconnect_pkg::*;
();

    localparam int    NR_MASTERS   = 4;
    localparam int    NR_BANKS     = 4;
    localparam int    BANK_SHIFT   = 2 + $clog2(NR_BANKS);
    localparam int    REGION_WORDS = 1024;
    localparam int    BANK_DEPTH   = REGION_WORDS / NR_BANKS;
    localparam addr_t INTLV_START  = 32'h1000_0000;
    localparam addr_t INTLV_END    = INTLV_START + 4 * REGION_WORDS - 1;
    localparam int    CONT_CYCLES  = 8 * NR_MASTERS;
    localparam int    RAND_OPS     = 40;
    // Upper bound on all five tests in cycles, the random test dominates
    localparam int    TEST_CYCLES  = 3 + 6 * NR_BANKS + 12 + CONT_CYCLES + 16
                                     + RAND_OPS * (NR_MASTERS + 3);
    localparam int    WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

    logic                  clk_i;
    logic                  reset_i;
    addr_t                 intlv_start_i;
    addr_t                 intlv_end_i;
    logic [NR_MASTERS-1:0] master_req_i;
    addr_t                 master_add_i [NR_MASTERS];
    logic [NR_MASTERS-1:0] master_wen_i;
    be_t                   master_be_i [NR_MASTERS];
    data_t                 master_wdata_i [NR_MASTERS];
    logic [NR_MASTERS-1:0] master_gnt_o;
    logic [NR_MASTERS-1:0] master_r_valid_o;
    data_t                 master_r_rdata_o [NR_MASTERS];
    logic [NR_MASTERS-1:0] master_r_opc_o;
    logic [NR_BANKS-1:0]   bank_req_o;
    addr_t                 bank_add_o [NR_BANKS];
    logic [NR_BANKS-1:0]   bank_wen_o;
    be_t                   bank_be_o [NR_BANKS];
    data_t                 bank_wdata_o [NR_BANKS];
    logic [NR_BANKS-1:0]   bank_gnt_i;
    data_t                 bank_rdata_i [NR_BANKS];

    logic [NR_BANKS-1:0]   bank_stall;
    logic [NR_BANKS-1:0]   bank_hit;
    tcdm_req_t             bank_pend [NR_BANKS];
    data_t                 bank_mem [NR_BANKS][BANK_DEPTH];
    data_t                 ref_mem [REGION_WORDS];
    addr_t                 rnd_addr [NR_MASTERS][RAND_OPS];
    logic                  rnd_wen [NR_MASTERS][RAND_OPS];
    data_t                 rnd_wdata [NR_MASTERS][RAND_OPS];
    be_t                   rnd_be [NR_MASTERS][RAND_OPS];
    int                    last_grant [NR_MASTERS];
    int                    grant_nr;
    int                    seed = 32'hcb46_875e;
    int                    errors = 0;
    int                    test_base = 0;
    int                    tests_run = 0;
    int                    chk_seen = 0;

    soc_interconnect #(
        .NR_MASTERS (NR_MASTERS),
        .NR_BANKS   (NR_BANKS)
    ) i_soc_interconnect (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // SRAM bank model
    //////////////////////////////////////////////////

    // A bank stalls only when the test holds its stall flag
    assign bank_gnt_i = ~bank_stall;

    // The accepted request is captured at the rising edge
    always @(posedge clk_i) begin
        for (int b = 0; b < NR_BANKS; b++) begin
            bank_hit[b]  <= bank_req_o[b] & bank_gnt_i[b];
            bank_pend[b] <= '{addr:  bank_add_o[b] - (INTLV_START >> BANK_SHIFT),
                              wen:   bank_wen_o[b],
                              be:    bank_be_o[b],
                              wdata: bank_wdata_o[b]};
        end
    end

    // and served at the following falling edge, inside the one-cycle latency
    always @(negedge clk_i) begin
        for (int b = 0; b < NR_BANKS; b++) begin
            if (bank_hit[b] && bank_pend[b].wen) begin
                bank_rdata_i[b] = bank_mem[b][bank_pend[b].addr];
            end else if (bank_hit[b]) begin
                for (int k = 0; k < BE_WIDTH; k++) begin
                    if (bank_pend[b].be[k]) begin
                        bank_mem[b][bank_pend[b].addr][8*k +: 8] = bank_pend[b].wdata[8*k +: 8];
                    end
                end
            end
        end
    end

    // Power-up contents, different for every byte address
    function automatic data_t fill_word(addr_t addr);
        return addr ^ 32'h3C5A_96E1;
    endfunction

    task automatic log_failure(input string text);
        errors++;
        $display("%s", text);
    endtask

    task automatic end_test(input string name);
        int chk_new;
        // Let the assertions of the last rising edge settle first
        @(negedge clk_i);
        // Protocol assertions of the bound checker belong to the test that was running
        chk_new   = i_soc_interconnect.i_chk.fail_count - chk_seen;
        chk_seen += chk_new;
        errors   += chk_new;
        tests_run++;
        $display("test %0d (%s) finished with %0d errors", tests_run, name, errors - test_base);
        test_base = errors;
    endtask

    // One TCDM access by master m, checked against the region and interleaving rules
    task automatic access(input int m, input addr_t addr, input logic wen, input data_t wdata,
                          input be_t be, input bit solo);
        int    waited;
        int    bank;
        int    word;
        logic  in_range;
        data_t expected;
        waited   = 0;
        in_range = (addr >= INTLV_START) && (addr <= INTLV_END);
        bank     = (addr >> 2) % NR_BANKS;
        @(negedge clk_i);
        master_req_i[m]   = 1'b1;
        master_add_i[m]   = addr;
        master_wen_i[m]   = wen;
        master_be_i[m]    = be;
        master_wdata_i[m] = wdata;
        @(posedge clk_i);
        while (!master_gnt_o[m]) begin
            waited++;
            @(posedge clk_i);
        end
        if (in_range) begin
            word     = (addr - INTLV_START) >> 2;
            expected = ref_mem[word];
            assert (bank_req_o[bank] && bank_add_o[bank] == addr >> BANK_SHIFT)
                else log_failure($sformatf("mismatch at %0t: address %h of master %0d not on bank %0d",
                                           $time, addr, m, bank));
            for (int k = 0; k < BE_WIDTH; k++) begin
                if (!wen && be[k]) begin
                    ref_mem[word][8*k +: 8] = wdata[8*k +: 8];
                end
            end
        end else begin
            expected = ERROR_RESPONSE;
            assert (waited == 0)
                else log_failure($sformatf("Error slave kept master %0d waiting %0d cycles", m, waited));
            assert (!solo || bank_req_o == '0)
                else log_failure($sformatf("A bank was requested for out-of-range address %h", addr));
        end
        @(negedge clk_i);
        master_req_i[m] = 1'b0;
        @(posedge clk_i);
        assert (master_r_valid_o[m])
            else log_failure($sformatf("Master %0d got no response one cycle after its grant", m));
        assert (master_r_opc_o[m] == !in_range)
            else log_failure($sformatf("mismatch at %0t: r_opc %b for address %h, expected %b",
                                       $time, master_r_opc_o[m], addr, !in_range));
        assert (!wen || master_r_rdata_o[m] == expected)
            else log_failure($sformatf("mismatch at %0t: master %0d read %h at %h, expected %h",
                                       $time, m, master_r_rdata_o[m], addr, expected));
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        addr_t       addr;
        data_t       wdata;
        logic [31:0] rnd;
        reset_i        = 1'b1;
        intlv_start_i  = INTLV_START;
        intlv_end_i    = INTLV_END;
        // Masters already read during reset, one in range and the others outside
        master_req_i   = '1;
        master_wen_i   = '1;
        master_add_i   = '{default: '0};
        master_be_i    = '{default: '0};
        master_wdata_i = '{default: '0};
        master_add_i[1] = INTLV_START;
        bank_rdata_i   = '{default: '0};
        bank_stall     = '0;
        // Word w of the region lives in bank w mod NR_BANKS
        for (int w = 0; w < REGION_WORDS; w++) begin
            ref_mem[w] = fill_word(INTLV_START + 4 * w);
            bank_mem[w % NR_BANKS][w / NR_BANKS] = fill_word(INTLV_START + 4 * w);
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i      = 1'b0;
        master_req_i = '0;

        for (int b = 0; b < NR_BANKS; b++) begin
            addr  = INTLV_START + 4 * (b + NR_BANKS * (3 * b + 1));
            wdata = $random(seed);
            access(b % NR_MASTERS, addr, 1'b0, wdata, '1, 1'b0);
            access(b % NR_MASTERS, addr, 1'b1, '0, '1, 1'b0);
        end
        end_test("single-master round trip");

        access(1, INTLV_START - 4, 1'b1, '0, '1, 1'b1);
        access(2, INTLV_END + 1, 1'b1, '0, '1, 1'b1);
        access(3, 32'h0000_0000, 1'b0, 32'h1234_5678, '1, 1'b1);
        access(0, 32'hFFFF_FFFC, 1'b1, '0, '1, 1'b1);
        end_test("out-of-range access");

        // Every master reads a different word of bank 0 and never lets go
        @(negedge clk_i);
        for (int m = 0; m < NR_MASTERS; m++) begin
            master_req_i[m] = 1'b1;
            master_wen_i[m] = 1'b1;
            master_add_i[m] = INTLV_START + 4 * NR_BANKS * m;
            last_grant[m]   = -NR_MASTERS;
        end
        grant_nr = 0;
        repeat (CONT_CYCLES) begin
            @(posedge clk_i);
            for (int m = 0; m < NR_MASTERS; m++) begin
                if (master_gnt_o[m]) begin
                    assert (grant_nr - last_grant[m] >= NR_MASTERS)
                        else log_failure($sformatf("Master %0d granted twice within %0d grants",
                                                   m, NR_MASTERS));
                    last_grant[m] = grant_nr;
                    grant_nr++;
                end
            end
        end
        assert (grant_nr == CONT_CYCLES)
            else log_failure($sformatf("Bank 0 granted %0d times in %0d busy cycles",
                                       grant_nr, CONT_CYCLES));
        @(negedge clk_i);
        master_req_i = '0;
        @(posedge clk_i);
        end_test("contention");

        // Bank 1 stalls while banks 2 and 3 keep serving
        @(negedge clk_i);
        bank_stall[1] = 1'b1;
        fork
            access(0, INTLV_START + 4 * 1, 1'b1, '0, '1, 1'b0);
            access(1, INTLV_START + 4 * (NR_BANKS + 1), 1'b1, '0, '1, 1'b0);
            access(2, INTLV_START + 4 * 2, 1'b0, 32'hCAFE_0002, '1, 1'b0);
            access(3, INTLV_START + 4 * 3, 1'b1, '0, '1, 1'b0);
            begin
                repeat (5) @(posedge clk_i);
                assert (master_req_i[1:0] == 2'b11 && master_gnt_o[1:0] == '0
                        && master_req_i[3:2] == '0)
                    else log_failure("Stalled bank granted a master or a free bank did not serve");
                @(negedge clk_i);
                bank_stall = '0;
            end
        join
        end_test("bank stall");

        // Operations are drawn up front so the sequence does not depend on process order
        for (int m = 0; m < NR_MASTERS; m++) begin
            for (int i = 0; i < RAND_OPS; i++) begin
                rnd = $random(seed);
                if (rnd[3:0] < 4'd3) begin
                    rnd_addr[m][i] = rnd[4] ? INTLV_START - 4 * (rnd[12:5] + 1)
                                            : INTLV_END + 1 + 4 * rnd[12:5];
                end else begin
                    rnd_addr[m][i] = INTLV_START + 4 * rnd[25:16];
                end
                rnd_wen[m][i]   = rnd[30];
                rnd_be[m][i]    = rnd[29:26];
                rnd_wdata[m][i] = $random(seed);
            end
        end
        for (int m = 0; m < NR_MASTERS; m++) begin
            fork
                automatic int mi = m;
                for (int i = 0; i < RAND_OPS; i++) begin
                    access(mi, rnd_addr[mi][i], rnd_wen[mi][i], rnd_wdata[mi][i], rnd_be[mi][i],
                           1'b0);
                end
            join_none
        end
        wait fork;
        end_test("random traffic");

        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog against a master that is never granted or never answered
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_soc_interconnect
